// ==== project.f ====
+incdir+test
design/sifhPkg.sv
design/sampleFilter.sv
design/histogramBuilder.sv
design/peakDetector.sv
design/windowCalc.sv
design/sifhCore.sv
test/tb_sifhCore.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_sifhCore: project.f design/*.sv test/*.sv test/*.svh
	verilator --binary --timing --timescale 1ns/100ps -f project.f \
		--top-module tb_sifhCore -Mdir obj_dir

run: obj_dir/Vtb_sifhCore
	./obj_dir/Vtb_sifhCore | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f project.f \
		--top-module sifhCore

clean:
	rm -rf obj_dir $(LOG)

// ==== test/sifhStimulus.svh ====
// Stimulus table and reference model of the peak finder testbench, included inside the testbench module
`ifndef SIFH_STIMULUS_SVH
`define SIFH_STIMULUS_SVH

    //********************************************************************
    // Stimulus table
    //********************************************************************
    // One 64-bit word per pixel, pixel 0 leftmost
    // sample j of a pixel sits in byte j, j = sweep * DATA_NUM + sample
    typedef logic [0:PIXEL_NUM-1][63:0] frameT;

    localparam int FIXED_NUM = 4;

    string testName [FIXED_NUM] = '{
        "distinct mid-range peaks",
        "coarse peak in bin 0",
        "coarse peak in top bin",
        "out-of-window and tied samples"
    };

    frameT coarseTab [FIXED_NUM] = '{
        {64'h3C54905F315A5852, 64'hA1AF2FA3AC2BA7A0,
         64'h41407D727E717F70, 64'hC8C015C915C4C4C4},
        {64'h020933010E070503, 64'h000F81800D0C0B0A,
         64'h0000000000000000, 64'h04F4F4F404040404},
        {64'h302010F4F3F2F1F0, 64'hFFFFFFFFFFFFFFFF,
         64'h11FE7BFDFC7AFBFA, 64'hEFEFF0F0F0F0F0EF},
        {64'h3535353535353535, 64'h8080808080808080,
         64'h6060606060606060, 64'h2020202020202020}
    };

    frameT fineTab [FIXED_NUM] = '{
        {64'h4E12504E614E504E, 64'hA5C0A39CA3A39CA3,
         64'hFF006A756A756A6A, 64'hC7C8C1B8C1C1BFC1},
        {64'h1105201010050505, 64'hFF09090909000000,
         64'h0E0F0E0F0E0F0F0F, 64'h0C414001010C0C0C},
        {64'hEE00EFEFFEFEFEFE, 64'hF0F5F5F5F5F0F0F0,
         64'hE2E1E0F8F8F8F8F8, 64'h04030201F3F3F3F3},
        {64'h939291902C2A2C2A, 64'h8977FF007A857A85,
         64'h6F695B5050505050, 64'h5040FF1C29171000}
    };

    // Expected result vector, pixel 3 in the top byte
    logic [PIXEL_NUM-1:0][NP-1:0] expTab [FIXED_NUM] = '{
        32'hC16AA34E,
        32'h0C0F0905,
        32'hF3F8F5FE,
        32'h1C5B852A
    };

    //********************************************************************
    // Reference model
    //********************************************************************
    // Replays one pixel's samples of a pass and returns the winning bin
    function automatic int findPeak(input logic [63:0] samples, input bit fine,
                                    input int lower, input int upper);
        int count [HIST_BINS];
        int peakBin;
        int peakCount;
        int s;
        int bin;
        for (int b = 0; b < HIST_BINS; b++) begin
            count[b] = 0;
        end
        peakBin   = 0;
        peakCount = 0;
        for (int j = 0; j < DATA_NUM * ACQ_NUM; j++) begin
            s = int'(samples[NP*j +: NP]);
            if (!fine) begin
                // Coarse pass keeps the top bits only
                bin = s >> (NP - NB);
            end else if (s >= lower && s <= upper) begin
                bin = (s - lower) % HIST_BINS;
            end else begin
                // Dropped sample
                bin = -1;
            end
            if (bin >= 0) begin
                count[bin]++;
                // Strictly greater, ties keep the earlier bin
                if (count[bin] > peakCount) begin
                    peakCount = count[bin];
                    peakBin   = bin;
                end
            end
        end
        return peakBin;
    endfunction

    // Clamped window around a coarse bin
    function automatic void windowBounds(input int bin, output int lower, output int upper);
        int ch;
        ch = bin << (NP - NB);
        if (ch > SAMPLE_MAX - 2 * SB - 1) begin
            upper = SAMPLE_MAX;
            lower = SAMPLE_MAX - 2 * SB;
        end else if (ch <= SB) begin
            lower = 0;
            upper = 2 * SB;
        end else begin
            lower = ch - SB;
            upper = ch + SB;
        end
    endfunction

    function automatic logic [PIXEL_NUM-1:0][NP-1:0] expectedResult(input frameT coarse,
                                                                      input frameT fine);
        logic [PIXEL_NUM-1:0][NP-1:0] res;
        int lower;
        int upper;
        int bin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            windowBounds(findPeak(coarse[p], 1'b0, 0, SAMPLE_MAX), lower, upper);
            bin    = findPeak(fine[p], 1'b1, lower, upper);
            res[p] = NP'(bin + lower);
        end
        return res;
    endfunction

`endif

// ==== test/tb_sifhCore.sv ====
// Self-checking testbench of the peak finder, runs the stimulus table and random frames through the DUT
module tb_sifhCore
    import sifhPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic                         clk;
    logic                         combin_res;
    logic                         wrEn;
    logic [NP-1:0]                data;
    logic [PIXEL_NUM-1:0][NP-1:0] result;
    logic                         resultValid;
    passT                         pass;

    int     errorCount;
    int     testCount;
    integer seed = 32'h73d1;

    `include "sifhStimulus.svh"

    sifhCore dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid),
        .pass        (pass)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //********************************************************************
    // Helpers
    //********************************************************************
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
    endtask

    // Sweeps outermost, then pixels, then samples
    task automatic drivePass(input frameT samples);
        for (int s = 0; s < ACQ_NUM; s++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int k = 0; k < DATA_NUM; k++) begin
                    @(negedge clk);
                    wrEn = 1'b1;
                    data = samples[p][NP * (s * DATA_NUM + k) +: NP];
                end
            end
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic waitForPass(input passT target);
        int cycles;
        cycles = 0;
        while (pass !== target && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (pass !== target) begin
            $display("Timeout: pass did not turn to %s within 200 cycles", target.name());
            errorCount++;
        end
    endtask

    // Coarse pass, turnaround, fine pass, then the result check
    task automatic runFrame(input frameT coarse, input frameT fine,
                            input logic [PIXEL_NUM-1:0][NP-1:0] expected);
        int cycles;
        drivePass(coarse);
        // Windows load one edge after pass flips
        waitForPass(finePass);
        drivePass(fine);
        cycles = 0;
        while (resultValid !== 1'b1 && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (resultValid !== 1'b1) begin
            $display("Timeout: resultValid did not rise within 200 cycles after the fine pass");
            errorCount++;
        end else begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                checkValue($sformatf("result[%0d]", p), 32'(result[p]), 32'(expected[p]));
            end
            checkValue("pass", 32'(pass), 32'(coarsePass));
        end
    endtask

    // Fine samples stay near the coarse ones so some land in the window
    task automatic randomFrame(output frameT coarse, output frameT fine);
        logic [NP-1:0] sample;
        logic [NP-1:0] jitter;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int j = 0; j < DATA_NUM * ACQ_NUM; j++) begin
                sample = NP'($random(seed));
                jitter = NP'($random(seed)) & NP'(8'h0F);
                coarse[p][NP*j +: NP] = sample;
                fine[p][NP*j +: NP]   = sample ^ jitter;
            end
        end
    endtask

    //********************************************************************
    // Test sequence
    //********************************************************************
    initial begin
        frameT coarse;
        frameT fine;
        int    errorsBefore;
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        errorCount = 0;
        testCount  = 0;
        // Two rising edges in reset, released on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;

        // Reset values
        @(negedge clk);
        errorsBefore = errorCount;
        checkValue("resultValid", 32'(resultValid), 32'h0);
        checkValue("pass", 32'(pass), 32'(coarsePass));
        checkValue("result", 32'(result), 32'h0);
        reportTest("reset values", errorsBefore);

        // Table rows
        for (int t = 0; t < FIXED_NUM; t++) begin
            errorsBefore = errorCount;
            runFrame(coarseTab[t], fineTab[t], expTab[t]);
            reportTest(testName[t], errorsBefore);
        end

        // Back-to-back random frames, stale bins must not leak
        for (int f = 0; f < 2; f++) begin
            errorsBefore = errorCount;
            randomFrame(coarse, fine);
            runFrame(coarse, fine, expectedResult(coarse, fine));
            reportTest($sformatf("random frame %0d", f + 1), errorsBefore);
        end

        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== design/sifhCore.sv ====
// Top level of the two-pass SiFH peak finder, the block to instantiate as the DUT
module sifhCore
    import sifhPkg::*;
(
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         wrEn,
    input  logic [NP-1:0]                data,
    output logic [PIXEL_NUM-1:0][NP-1:0] result,
    output logic                         resultValid,
    output passT                         pass
);

    //********************************************************************
    // Data path
    //   sampleFilter -> histogramBuilder -> peakDetector -> windowCalc
    //        ^                                                |
    //        +---------------- per-pixel windows -------------+
    //********************************************************************
    // Pass turnaround
    // passDone rises one edge after the last sample of a pass and the
    // windows load one edge later, so wrEn stays low for two cycles
    // before the first sample of the next pass

    logic [NB-1:0]          binAddr;
    logic                   inWindow;
    logic [PIX_W-1:0]       pixelIdx;
    binEventT               binEvent;
    logic                   passDone;
    peakT [PIXEL_NUM-1:0]   peaks;
    windowT [PIXEL_NUM-1:0] windows;
    windowT                 curWindow;

    // Window of the pixel being sampled
    assign curWindow = windows[pixelIdx];

    sampleFilter uFilter (
        .data     (data),
        .pass     (pass),
        .window   (curWindow),
        .binAddr  (binAddr),
        .inWindow (inWindow)
    );

    histogramBuilder uHist (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .binAddr    (binAddr),
        .inWindow   (inWindow),
        .pixelIdx   (pixelIdx),
        .pass       (pass),
        .binEvent   (binEvent),
        .passDone   (passDone)
    );

    peakDetector uPeak (
        .clk        (clk),
        .combin_res (combin_res),
        .binEvent   (binEvent),
        .passDone   (passDone),
        .peaks      (peaks)
    );

    windowCalc uWindow (
        .clk         (clk),
        .combin_res  (combin_res),
        .passDone    (passDone),
        .pass        (pass),
        .peaks       (peaks),
        .windows     (windows),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

// ==== design/windowCalc.sv ====
// Turns coarse peaks into clamped per-pixel windows and fine peaks into the final results
module windowCalc
    import sifhPkg::*;
(
    input  logic                         clk,
    input  logic                         combin_res,
    input  logic                         passDone,
    input  passT                         pass,
    input  peakT [PIXEL_NUM-1:0]         peaks,
    output windowT [PIXEL_NUM-1:0]       windows,
    output logic [PIXEL_NUM-1:0][NP-1:0] result,
    output logic                         resultValid
);

    //********************************************************************
    // Window rule
    //********************************************************************
    function automatic windowT clampWindow(input logic [NB-1:0] bin);
        logic [NP-1:0] ch;
        windowT        w;
        // Coarse bin back on the sample scale
        ch = {bin, {(NP - NB){1'b0}}};
        if (ch > NP'(SAMPLE_MAX - 2 * SB - 1)) begin
            // Pinned to the top of the range
            w.upper = NP'(SAMPLE_MAX);
            w.lower = NP'(SAMPLE_MAX - 2 * SB);
        end else if (ch <= NP'(SB)) begin
            w.lower = '0;
            w.upper = NP'(2 * SB);
        end else begin
            w.lower = ch - NP'(SB);
            w.upper = ch + NP'(SB);
        end
        return w;
    endfunction

    windowT [PIXEL_NUM-1:0]       nextWindows;
    logic [PIXEL_NUM-1:0][NP-1:0] nextResult;
    logic                         coarseEnded;
    logic                         fineEnded;

    // Pass has already flipped while passDone is high
    assign coarseEnded = passDone && (pass == finePass);
    assign fineEnded   = passDone && (pass == coarsePass);

    always_comb begin
        for (int i = 0; i < PIXEL_NUM; i++) begin
            nextWindows[i] = clampWindow(peaks[i].bin);
            // Fine bin back to the absolute sample value
            nextResult[i]  = {{(NP - NB){1'b0}}, peaks[i].bin} + windows[i].lower;
        end
    end

    //********************************************************************
    // Window and result registers
    //********************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windows     <= '0;
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= fineEnded;
            // Windows hold through the whole fine pass
            if (coarseEnded) begin
                windows <= nextWindows;
            end
            if (fineEnded) begin
                result <= nextResult;
            end
        end
    end

endmodule

// ==== design/peakDetector.sv ====
// Running per-pixel maximum of the histogram counts, restarted at every pass end
module peakDetector
    import sifhPkg::*;
(
    input  logic                   clk,
    input  logic                   combin_res,
    input  binEventT               binEvent,
    input  logic                   passDone,
    output peakT [PIXEL_NUM-1:0]   peaks
);

    //********************************************************************
    // Compare
    //********************************************************************
    // Current best of the event's pixel
    peakT stored;
    peakT candidate;
    logic beats;

    assign stored = peaks[binEvent.pixel];

    assign candidate.bin   = binEvent.bin;
    assign candidate.count = binEvent.count;

    // Strictly greater only
    // on a tie the earlier bin stays
    assign beats = binEvent.valid && (binEvent.count > stored.count);

    //********************************************************************
    // Peak registers
    //********************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peaks <= '0;
        end else if (passDone) begin
            // Last event of the pass landed one edge earlier
            peaks <= '0;
        end else if (beats) begin
            peaks[binEvent.pixel] <= candidate;
        end
    end

    // A pixel with no accepted sample keeps bin 0 with count 0

endmodule

// ==== design/histogramBuilder.sv ====
// Per-pixel bin counters with lazy clear, plus the sample, pixel, sweep and pass sequencing
module histogramBuilder
    import sifhPkg::*;
(
    input  logic             clk,
    input  logic             combin_res,
    input  logic             wrEn,
    input  logic [NB-1:0]    binAddr,
    input  logic             inWindow,
    output logic [PIX_W-1:0] pixelIdx,
    output passT             pass,
    output binEventT         binEvent,
    output logic             passDone
);

    //********************************************************************
    // Storage
    //********************************************************************
    logic [COUNT_W-1:0] countMem [BIN_NUM];
    // One valid bit per bin, clear means empty
    logic [BIN_NUM-1:0] binValid;

    logic [SAMPLE_W-1:0] sampleCnt;
    logic [SWEEP_W-1:0]  sweepCnt;

    logic [BIN_W-1:0]   binIdx;
    logic [COUNT_W-1:0] newCount;
    logic               accept;
    logic               sampleEnd;
    logic               pixelEnd;
    logic               sweepEnd;
    logic               passEnd;
    // Last sample of the pass was taken on the previous edge
    logic               lastSeen;

    // Pixel histograms sit back to back
    assign binIdx = {pixelIdx, binAddr};
    assign accept = wrEn && inWindow;

    // Stale bins read as empty
    assign newCount = binValid[binIdx] ? (countMem[binIdx] + COUNT_W'(1)) : COUNT_W'(1);

    assign sampleEnd = (sampleCnt == SAMPLE_W'(DATA_NUM - 1));
    assign pixelEnd  = (pixelIdx == PIX_W'(PIXEL_NUM - 1));
    assign sweepEnd  = (sweepCnt == SWEEP_W'(ACQ_NUM - 1));
    assign passEnd   = sampleEnd && pixelEnd && sweepEnd;

    //********************************************************************
    // Position counters
    //********************************************************************
    // Every strobe advances, in window or not
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelIdx  <= '0;
            sweepCnt  <= '0;
        end else if (wrEn) begin
            if (sampleEnd) begin
                sampleCnt <= '0;
                if (pixelEnd) begin
                    pixelIdx <= '0;
                    sweepCnt <= sweepEnd ? '0 : sweepCnt + 1'b1;
                end else begin
                    pixelIdx <= pixelIdx + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    //********************************************************************
    // Histogram update and pass control
    //********************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            binEvent <= '0;
            lastSeen <= 1'b0;
            passDone <= 1'b0;
            pass     <= coarsePass;
        end else begin
            lastSeen       <= wrEn && passEnd;
            passDone       <= lastSeen;
            binEvent.valid <= accept;
            if (accept) begin
                binEvent.pixel   <= pixelIdx;
                binEvent.bin     <= binAddr;
                binEvent.count   <= newCount;
                binValid[binIdx] <= 1'b1;
            end
            // Pass turnaround
            // all bins go stale at once, counts stay in place
            if (lastSeen) begin
                binValid <= '0;
                pass     <= (pass == coarsePass) ? finePass : coarsePass;
            end
        end
    end

    // Count words, validity lives in binValid
    always_ff @(posedge clk) begin
        if (accept) begin
            countMem[binIdx] <= newCount;
        end
    end

endmodule

// ==== design/sampleFilter.sv ====
// Combinational front end that turns a raw sample into a histogram bin address for the current pass
module sampleFilter
    import sifhPkg::*;
(
    input  logic [NP-1:0] data,
    input  passT          pass,
    input  windowT        window,
    output logic [NB-1:0] binAddr,
    output logic          inWindow
);

    //********************************************************************
    // Fine pass window test
    //********************************************************************
    // Offset from the lower bound
    // only the low NB bits of the difference are ever kept
    logic [NB-1:0] offset;
    logic          aboveLower;
    logic          belowUpper;

    assign offset = data[NB-1:0] - window.lower[NB-1:0];

    // Both bounds inclusive
    assign aboveLower = (data >= window.lower);
    assign belowUpper = (data <= window.upper);

    //********************************************************************
    // Address select
    //********************************************************************
    always_comb begin
        if (pass == coarsePass) begin
            // Top NB bits, every sample counts
            binAddr  = data[NP-1 -: NB];
            inWindow = 1'b1;
        end else begin
            // Full resolution inside the window
            binAddr  = offset;
            inWindow = aboveLower && belowUpper;
        end
    end

    // Note: an upper bound 2*SB above the lower one gives an offset of
    // 2*SB for the top sample, which wraps onto bin 0

endmodule

// ==== design/sifhPkg.sv ====
// Sizes, pass encoding and bus structs of the SiFH peak finder, imported by every block and the testbench
package sifhPkg;

    //********************************************************************
    // Sizes
    //********************************************************************
    // Sample width
    localparam int NP         = 8;
    // Coarse bin address width
    localparam int NB         = 4;
    localparam int PIXEL_NUM  = 4;
    // Samples per pixel in one sweep
    localparam int DATA_NUM   = 2;
    // Sweeps per pass
    localparam int ACQ_NUM    = 4;

    // Bins per pixel histogram
    localparam int HIST_BINS  = 2 ** NB;
    localparam int BIN_NUM    = PIXEL_NUM * HIST_BINS;
    // Room for every sample of a pixel in one bin
    localparam int COUNT_W    = $clog2(DATA_NUM * ACQ_NUM + 1);
    // Half window width
    localparam int SB         = 2 ** (NB - 1);
    localparam int SAMPLE_MAX = 2 ** NP - 1;

    // Counter and index widths
    localparam int PIX_W      = $clog2(PIXEL_NUM);
    localparam int SAMPLE_W   = $clog2(DATA_NUM);
    localparam int SWEEP_W    = $clog2(ACQ_NUM);
    localparam int BIN_W      = $clog2(BIN_NUM);

    //********************************************************************
    // Types
    //********************************************************************
    typedef enum logic {
        coarsePass = 1'b0,
        finePass   = 1'b1
    } passT;

    // One histogram update, new count already applied
    typedef struct packed {
        logic               valid;
        logic [PIX_W-1:0]   pixel;
        logic [NB-1:0]      bin;
        logic [COUNT_W-1:0] count;
    } binEventT;

    // Inclusive sample window of one pixel
    typedef struct packed {
        logic [NP-1:0] lower;
        logic [NP-1:0] upper;
    } windowT;

    typedef struct packed {
        logic [NB-1:0]      bin;
        logic [COUNT_W-1:0] count;
    } peakT;

endpackage
